// ==== ooo_dispatch.f ====
+incdir+hdl
hdl/rename_pkg.sv
hdl/inst_pkg.sv
hdl/dispatch_ctrl.sv
hdl/map_table.sv
hdl/reorder_buffer.sv
hdl/operand_select.sv
hdl/register_file.sv
hdl/ooo_dispatch.sv
test/ooo_dispatch_properties.sv
test/ooo_dispatch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module ooo_dispatch_tb \
    -f ooo_dispatch.f -o ooo_dispatch_sim

sim_out=$(./obj_dir/ooo_dispatch_sim) || true
printf '%s\n' "$sim_out"

# the run counts as passed only if the pass line shows up
printf '%s\n' "$sim_out" | grep -q '^TESTS PASSED$'

// ==== test/ooo_dispatch_tb.sv ====
`timescale 1ns/100ps

`include "dispatch_consts.svh"

module ooo_dispatch_tb;
    import rename_pkg::*;
    import inst_pkg::*;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 16;
    localparam int max_rows     = 64;

    typedef struct packed {
        logic           strobe;
        decoded_pack_t  decoded;
        logic [3:0]     rs_full;
        cdb_packet_t    cdb;
        logic [3:0]     exp_rs_load;
        logic           exp_stall;
        rs_entry_t      exp_entry;
        retire_packet_t exp_retire;
    } row_t;

    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        xlen_t    value;
    } operand_t;

    logic           clk = 1'b0;
    logic           reset;
    logic           decoded_valid;
    decoded_pack_t  decoded;
    logic [3:0]     rs_full;
    cdb_packet_t    cdb;
    logic [3:0]     rs_load;
    rs_entry_t      rs_entry;
    logic           stall;
    retire_packet_t retire;

    row_t        rows [max_rows];
    int          n_rows = 0;
    logic [31:0] rng_state;

    // reference model state
    logic          m_held_valid;
    decoded_pack_t m_held;
    logic          m_busy [`REG_NUM];
    rob_tag_t      m_tag [`REG_NUM];
    xlen_t         m_regs [`REG_NUM];
    reg_addr_t     m_rob_dest [`ROB_SIZE];
    logic          m_rob_ready [`ROB_SIZE];
    xlen_t         m_rob_val [`ROB_SIZE];
    rob_tag_t      m_head;
    rob_tag_t      m_tail;
    int            m_count;

    ooo_dispatch ooo_dispatch_i (
        .clk           (clk),
        .reset         (reset),
        .decoded_valid (decoded_valid),
        .decoded       (decoded),
        .rs_full       (rs_full),
        .cdb           (cdb),
        .rs_load       (rs_load),
        .rs_entry      (rs_entry),
        .stall         (stall),
        .retire        (retire)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is 0x%h, expected 0x%h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    function automatic xlen_t xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic decoded_pack_t make_inst(fu_e fu, logic [3:0] func, reg_addr_t dest,
                                                logic has_dest, reg_addr_t src1,
                                                reg_addr_t src2);
        decoded_pack_t d;
        d          = '0;
        d.fu       = fu;
        d.func     = func;
        d.dest     = dest;
        d.has_dest = has_dest;
        d.src1     = src1;
        d.src2     = src2;
        return d;
    endfunction

    task automatic add_row(input logic strobe, input decoded_pack_t d, input logic [3:0] full,
                           input logic cdb_on, input rob_tag_t cdb_tag);
        row_t r;
        r         = '0;
        r.strobe  = strobe;
        r.decoded = d;
        r.rs_full = full;
        if (cdb_on) begin
            r.cdb.valid = 1'b1;
            r.cdb.tag   = cdb_tag;
            r.cdb.data  = xorshift32();
        end
        rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic idle_row(input logic cdb_on, input rob_tag_t cdb_tag);
        add_row(1'b0, '0, 4'b0000, cdb_on, cdb_tag);
    endtask

    task automatic build_table();
        decoded_pack_t d;
        // independent ALU op right after reset
        add_row(1'b1, make_inst(FU_ALU, 4'h2, 5'd1, 1'b1, 5'd2, 5'd3), 4'b0000, 1'b0, 3'd0);
        idle_row(1'b0, 3'd0);
        // MULT reads r1 while tag 0 is still pending
        add_row(1'b1, make_inst(FU_MULT, 4'h5, 5'd4, 1'b1, 5'd1, 5'd0), 4'b0000, 1'b0, 3'd0);
        idle_row(1'b0, 3'd0);
        // tag 0 completes, then r4 meets the tag 1 broadcast in its dispatch cycle
        add_row(1'b1, make_inst(FU_ALU, 4'h1, 5'd5, 1'b1, 5'd1, 5'd4), 4'b0000, 1'b1, 3'd0);
        idle_row(1'b1, 3'd1);
        add_row(1'b1, make_inst(FU_ALU, 4'h3, 5'd6, 1'b1, 5'd1, 5'd4), 4'b0000, 1'b0, 3'd0);
        idle_row(1'b0, 3'd0);
        // younger tag finishes first, retirement stays in order
        idle_row(1'b1, 3'd3);
        idle_row(1'b1, 3'd2);
        idle_row(1'b0, 3'd0);
        idle_row(1'b0, 3'd0);
        // LSU held by its own full station only
        add_row(1'b1, make_inst(FU_LSU, 4'h8, 5'd7, 1'b1, 5'd5, 5'd6), 4'b1000, 1'b0, 3'd0);
        add_row(1'b0, '0, 4'b1000, 1'b0, 3'd0);
        add_row(1'b0, '0, 4'b1000, 1'b0, 3'd0);
        add_row(1'b0, '0, 4'b0100, 1'b0, 3'd0);
        // seven back-to-back ops waiting on r7 fill the ROB
        for (int k = 0; k < 7; k++) begin
            add_row(1'b1, make_inst(FU_ALU, 4'h1, reg_addr_t'(8 + k), 1'b1, 5'd7, 5'd0),
                    4'b0000, 1'b0, 3'd0);
        end
        idle_row(1'b0, 3'd0);
        add_row(1'b1, make_inst(FU_ALU, 4'h4, 5'd8, 1'b1, 5'd7, 5'd8), 4'b0000, 1'b0, 3'd0);
        idle_row(1'b0, 3'd0);
        idle_row(1'b1, 3'd4);
        idle_row(1'b0, 3'd0);
        idle_row(1'b1, 3'd5);
        // pc and imm stand in for both sources
        d           = make_inst(FU_ALU, 4'h6, 5'd15, 1'b1, 5'd8, 5'd9);
        d.pc        = 32'h0000_1000;
        d.pc_valid  = 1'b1;
        d.imm       = 32'h0000_007f;
        d.imm_valid = 1'b1;
        add_row(1'b1, d, 4'b0000, 1'b1, 3'd6);
        idle_row(1'b1, 3'd7);
        // branch reads its registers and carries imm and pc aside
        d           = make_inst(FU_BTU, 4'h3, 5'd0, 1'b0, 5'd9, 5'd10);
        d.pc        = 32'h0000_2000;
        d.pc_valid  = 1'b1;
        d.imm       = 32'h0000_0020;
        d.imm_valid = 1'b1;
        add_row(1'b1, d, 4'b0000, 1'b0, 3'd0);
        idle_row(1'b0, 3'd0);
        idle_row(1'b0, 3'd0);
    endtask

    // rename status, then ROB or same-cycle broadcast
    function automatic operand_t resolve_src(reg_addr_t a, cdb_packet_t bus);
        operand_t op;
        op.tag   = m_tag[a];
        op.ready = 1'b1;
        op.value = m_regs[a];
        if (m_busy[a]) begin
            if (bus.valid && (bus.tag == m_tag[a])) begin
                op.value = bus.data;
            end else if (m_rob_ready[m_tag[a]]) begin
                op.value = m_rob_val[m_tag[a]];
            end else begin
                op.ready = 1'b0;
                op.value = '0;
            end
        end
        return op;
    endfunction

    task automatic predict(input int i);
        logic           fire_now;
        rs_entry_t      e;
        retire_packet_t ret;
        operand_t       op1;
        operand_t       op2;
        fire_now = m_held_valid && !rows[i].rs_full[m_held.fu] && (m_count != `ROB_SIZE);
        rows[i].exp_stall   = m_held_valid && !fire_now;
        rows[i].exp_rs_load = fire_now ? (4'b0001 << m_held.fu) : 4'b0000;
        if (rows[i].strobe && rows[i].exp_stall) begin
            $display("stimulus row %0d strobes while dispatch is stalled", i);
            abort_run();
        end
        ret.valid    = (m_count != 0) && m_rob_ready[m_head];
        ret.reg_addr = m_rob_dest[m_head];
        ret.data     = m_rob_val[m_head];
        rows[i].exp_retire = ret;
        e = '0;
        if (fire_now) begin
            op1          = resolve_src(m_held.src1, rows[i].cdb);
            op2          = resolve_src(m_held.src2, rows[i].cdb);
            e.fu         = m_held.fu;
            e.func       = m_held.func;
            e.tag_dest   = m_tail;
            e.tag_src1   = op1.tag;
            e.tag_src2   = op2.tag;
            e.ready_src1 = op1.ready;
            e.ready_src2 = op2.ready;
            e.value_src1 = op1.value;
            e.value_src2 = op2.value;
            if (m_held.fu == FU_BTU) begin
                e.imm = m_held.imm;
                e.pc  = m_held.pc;
            end else begin
                if (m_held.pc_valid) begin
                    e.ready_src1 = 1'b1;
                    e.value_src1 = m_held.pc;
                end
                if (m_held.imm_valid) begin
                    e.ready_src2 = 1'b1;
                    e.value_src2 = m_held.imm;
                end
            end
        end
        rows[i].exp_entry = e;
        // state at the next rising edge, rename after retire
        if (ret.valid) begin
            if (ret.reg_addr != '0) begin
                m_regs[ret.reg_addr] = ret.data;
            end
            if (m_busy[ret.reg_addr] && (m_tag[ret.reg_addr] == m_head)) begin
                m_busy[ret.reg_addr] = 1'b0;
                m_tag[ret.reg_addr]  = '0;
            end
            m_head = m_head + 1'b1;
            m_count--;
        end
        if (fire_now) begin
            m_rob_dest[m_tail]  = m_held.has_dest ? m_held.dest : '0;
            m_rob_ready[m_tail] = 1'b0;
            if (m_held.has_dest && (m_held.dest != '0)) begin
                m_busy[m_held.dest] = 1'b1;
                m_tag[m_held.dest]  = m_tail;
            end
            m_tail = m_tail + 1'b1;
            m_count++;
        end
        if (rows[i].cdb.valid) begin
            m_rob_ready[rows[i].cdb.tag] = 1'b1;
            m_rob_val[rows[i].cdb.tag]   = rows[i].cdb.data;
        end
        if (rows[i].strobe) begin
            m_held       = rows[i].decoded;
            m_held_valid = 1'b1;
        end else if (fire_now) begin
            m_held_valid = 1'b0;
        end
    endtask

    task automatic run_model();
        m_held_valid = 1'b0;
        m_held       = '0;
        m_head       = '0;
        m_tail       = '0;
        m_count      = 0;
        for (int r = 0; r < `REG_NUM; r++) begin
            m_busy[r] = 1'b0;
            m_tag[r]  = '0;
            m_regs[r] = '0;
        end
        for (int t = 0; t < `ROB_SIZE; t++) begin
            m_rob_dest[t]  = '0;
            m_rob_ready[t] = 1'b0;
            m_rob_val[t]   = '0;
        end
        for (int i = 0; i < n_rows; i++) begin
            predict(i);
        end
    endtask

    task automatic compare_row(input int i);
        row_t r;
        r = rows[i];
        check_value("stall", 32'(stall), 32'(r.exp_stall));
        check_value("rs_load", 32'(rs_load), 32'(r.exp_rs_load));
        check_value("retire.valid", 32'(retire.valid), 32'(r.exp_retire.valid));
        if (r.exp_retire.valid) begin
            check_value("retire.reg_addr", 32'(retire.reg_addr), 32'(r.exp_retire.reg_addr));
            check_value("retire.data", retire.data, r.exp_retire.data);
        end
        if (r.exp_rs_load != 4'b0000) begin
            check_value("rs_entry.fu", 32'(rs_entry.fu), 32'(r.exp_entry.fu));
            check_value("rs_entry.func", 32'(rs_entry.func), 32'(r.exp_entry.func));
            check_value("rs_entry.tag_dest", 32'(rs_entry.tag_dest), 32'(r.exp_entry.tag_dest));
            check_value("rs_entry.tag_src1", 32'(rs_entry.tag_src1), 32'(r.exp_entry.tag_src1));
            check_value("rs_entry.tag_src2", 32'(rs_entry.tag_src2), 32'(r.exp_entry.tag_src2));
            check_value("rs_entry.ready_src1", 32'(rs_entry.ready_src1),
                        32'(r.exp_entry.ready_src1));
            check_value("rs_entry.ready_src2", 32'(rs_entry.ready_src2),
                        32'(r.exp_entry.ready_src2));
            check_value("rs_entry.value_src1", rs_entry.value_src1, r.exp_entry.value_src1);
            check_value("rs_entry.value_src2", rs_entry.value_src2, r.exp_entry.value_src2);
            check_value("rs_entry.imm", rs_entry.imm, r.exp_entry.imm);
            check_value("rs_entry.pc", rs_entry.pc, r.exp_entry.pc);
        end
    endtask

    // run length follows the table size
    initial begin
        wait (n_rows > 0);
        #((reset_cycles + n_rows + 4) * clk_period + 40);
        $display("watchdog expired before the stimulus table finished");
        abort_run();
    end

    initial begin
        reset         = 1'b1;
        decoded_valid = 1'b0;
        decoded       = '0;
        rs_full       = '0;
        cdb           = '0;
        rng_state     = 32'd17;
        build_table();
        run_model();

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // drive on the falling edge, sample a quarter period later
        for (int i = 0; i < n_rows; i++) begin
            @(negedge clk);
            decoded_valid = rows[i].strobe;
            decoded       = rows[i].decoded;
            rs_full       = rows[i].rs_full;
            cdb           = rows[i].cdb;
            #1;
            compare_row(i);
        end

        @(negedge clk);
        decoded_valid = 1'b0;
        rs_full       = '0;
        cdb           = '0;
        @(negedge clk);

        if (ooo_dispatch_i.ooo_dispatch_properties_i.failed) begin
            $display("a bound assertion failed during the run");
            abort_run();
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== test/ooo_dispatch_properties.sv ====
`timescale 1ns/100ps

`include "dispatch_consts.svh"

module ooo_dispatch_properties (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`FU_NUM-1:0]         rs_load,
    input  logic                       stall,
    input  rename_pkg::retire_packet_t retire
);

    logic load_bad    = 1'b0;
    logic overlap_bad = 1'b0;
    logic retire_bad  = 1'b0;
    logic failed;

    assign failed = load_bad | overlap_bad | retire_bad;

    rs_load_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(rs_load))
        else begin
            load_bad <= 1'b1;
            $error("rs_load selects more than one station: %b", rs_load);
        end

    no_load_while_stalled: assert property (@(posedge clk) disable iff (reset)
        !(stall && (rs_load != '0)))
        else begin
            overlap_bad <= 1'b1;
            $error("stall and rs_load are high together");
        end

    // first cycle out of reset has nothing to retire
    retire_idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !retire.valid)
        else begin
            retire_bad <= 1'b1;
            $error("retire is valid right after reset");
        end

endmodule

bind ooo_dispatch ooo_dispatch_properties ooo_dispatch_properties_i (
    .clk     (clk),
    .reset   (reset),
    .rs_load (rs_load),
    .stall   (stall),
    .retire  (retire)
);

// ==== hdl/ooo_dispatch.sv ====
`timescale 1ns/100ps

`include "dispatch_consts.svh"

module ooo_dispatch (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       decoded_valid,
    input  inst_pkg::decoded_pack_t    decoded,
    input  logic [`FU_NUM-1:0]         rs_full,
    input  rename_pkg::cdb_packet_t    cdb,
    output logic [`FU_NUM-1:0]         rs_load,
    output inst_pkg::rs_entry_t        rs_entry,
    output logic                       stall,
    output rename_pkg::retire_packet_t retire
);
    import rename_pkg::*;
    import inst_pkg::*;

    decoded_pack_t held;
    logic          fire;
    logic          rob_full;
    rob_tag_t      alloc_tag;
    rob_tag_t      retire_tag;
    map_entry_t    map_src1;
    map_entry_t    map_src2;
    xlen_t         rf_data1;
    xlen_t         rf_data2;
    logic          rob_ready1;
    logic          rob_ready2;
    xlen_t         rob_value1;
    xlen_t         rob_value2;

    dispatch_ctrl dispatch_ctrl_i (
        .clk           (clk),
        .reset         (reset),
        .decoded_valid (decoded_valid),
        .decoded       (decoded),
        .rs_full       (rs_full),
        .rob_full      (rob_full),
        .held          (held),
        .fire          (fire),
        .rs_load       (rs_load),
        .stall         (stall)
    );

    map_table map_table_i (
        .clk        (clk),
        .reset      (reset),
        .src1       (held.src1),
        .src2       (held.src2),
        .map_src1   (map_src1),
        .map_src2   (map_src2),
        .alloc      (fire),
        .dest       (held.dest),
        .has_dest   (held.has_dest),
        .alloc_tag  (alloc_tag),
        .retire_tag (retire_tag),
        .retire     (retire)
    );

    // source tags from the map table index the ROB lookups
    reorder_buffer reorder_buffer_i (
        .clk            (clk),
        .reset          (reset),
        .alloc          (fire),
        .alloc_dest     (held.dest),
        .alloc_has_dest (held.has_dest),
        .alloc_tag      (alloc_tag),
        .rob_full       (rob_full),
        .cdb            (cdb),
        .query_tag1     (map_src1.tag),
        .query_tag2     (map_src2.tag),
        .ready1         (rob_ready1),
        .ready2         (rob_ready2),
        .value1         (rob_value1),
        .value2         (rob_value2),
        .retire_tag     (retire_tag),
        .retire         (retire)
    );

    register_file register_file_i (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (held.src1),
        .raddr2 (held.src2),
        .rdata1 (rf_data1),
        .rdata2 (rf_data2),
        .retire (retire)
    );

    operand_select operand_select_i (
        .held       (held),
        .map_src1   (map_src1),
        .map_src2   (map_src2),
        .rf_data1   (rf_data1),
        .rf_data2   (rf_data2),
        .rob_ready1 (rob_ready1),
        .rob_ready2 (rob_ready2),
        .rob_value1 (rob_value1),
        .rob_value2 (rob_value2),
        .cdb        (cdb),
        .alloc_tag  (alloc_tag),
        .rs_entry   (rs_entry)
    );

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/100ps

`include "dispatch_consts.svh"

module register_file (
    input  logic                       clk,
    input  logic                       reset,
    input  rename_pkg::reg_addr_t      raddr1,
    input  rename_pkg::reg_addr_t      raddr2,
    output rename_pkg::xlen_t          rdata1,
    output rename_pkg::xlen_t          rdata2,
    input  rename_pkg::retire_packet_t retire
);
    import rename_pkg::*;

    xlen_t regs [`REG_NUM];

    // r0 is never written, so it reads zero after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid && (retire.reg_addr != '0)) begin
            regs[retire.reg_addr] <= retire.data;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

// ==== hdl/operand_select.sv ====
`timescale 1ns/100ps

module operand_select (
    input  inst_pkg::decoded_pack_t held,
    input  rename_pkg::map_entry_t  map_src1,
    input  rename_pkg::map_entry_t  map_src2,
    input  rename_pkg::xlen_t       rf_data1,
    input  rename_pkg::xlen_t       rf_data2,
    input  logic                    rob_ready1,
    input  logic                    rob_ready2,
    input  rename_pkg::xlen_t       rob_value1,
    input  rename_pkg::xlen_t       rob_value2,
    input  rename_pkg::cdb_packet_t cdb,
    input  rename_pkg::rob_tag_t    alloc_tag,
    output inst_pkg::rs_entry_t     rs_entry
);
    import rename_pkg::*;
    import inst_pkg::*;

    src_stat_e stat1;
    src_stat_e stat2;

    function automatic logic cdb_match(map_entry_t m, cdb_packet_t bus);
        return bus.valid && (bus.tag == m.tag);
    endfunction

    function automatic src_stat_e source_status(map_entry_t m, logic rob_rdy, cdb_packet_t bus);
        src_stat_e stat;
        if (!m.busy) begin
            stat = SRC_REGFILE;
        end else if (rob_rdy || cdb_match(m, bus)) begin
            stat = SRC_ROB_READY;
        end else begin
            stat = SRC_PENDING;
        end
        return stat;
    endfunction

    function automatic xlen_t source_value(src_stat_e stat, map_entry_t m, xlen_t rf_data,
                                           xlen_t rob_value, cdb_packet_t bus);
        xlen_t value;
        case (stat)
            SRC_REGFILE:   value = rf_data;
            // same-cycle broadcast bypasses the ROB write
            SRC_ROB_READY: value = cdb_match(m, bus) ? bus.data : rob_value;
            default:       value = '0;
        endcase
        return value;
    endfunction

    assign stat1 = source_status(map_src1, rob_ready1, cdb);
    assign stat2 = source_status(map_src2, rob_ready2, cdb);

    always_comb begin
        rs_entry.fu         = held.fu;
        rs_entry.func       = held.func;
        rs_entry.tag_dest   = alloc_tag;
        rs_entry.tag_src1   = map_src1.tag;
        rs_entry.tag_src2   = map_src2.tag;
        rs_entry.ready_src1 = (stat1 != SRC_PENDING);
        rs_entry.ready_src2 = (stat2 != SRC_PENDING);
        rs_entry.value_src1 = source_value(stat1, map_src1, rf_data1, rob_value1, cdb);
        rs_entry.value_src2 = source_value(stat2, map_src2, rf_data2, rob_value2, cdb);
        rs_entry.imm        = '0;
        rs_entry.pc         = '0;

        if (held.fu == FU_BTU) begin
            // branches need registers and imm/pc side by side
            rs_entry.imm = held.imm;
            rs_entry.pc  = held.pc;
        end else begin
            if (held.pc_valid) begin
                rs_entry.ready_src1 = 1'b1;
                rs_entry.value_src1 = held.pc;
            end
            if (held.imm_valid) begin
                rs_entry.ready_src2 = 1'b1;
                rs_entry.value_src2 = held.imm;
            end
        end
    end

endmodule

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/100ps

`include "dispatch_consts.svh"

module reorder_buffer (
    input  logic                       clk,
    input  logic                       reset,

    // allocation at the tail on dispatch
    input  logic                       alloc,
    input  rename_pkg::reg_addr_t      alloc_dest,
    input  logic                       alloc_has_dest,
    output rename_pkg::rob_tag_t       alloc_tag,
    output logic                       rob_full,

    // completions
    input  rename_pkg::cdb_packet_t    cdb,

    // operand lookups by tag
    input  rename_pkg::rob_tag_t       query_tag1,
    input  rename_pkg::rob_tag_t       query_tag2,
    output logic                       ready1,
    output logic                       ready2,
    output rename_pkg::xlen_t          value1,
    output rename_pkg::xlen_t          value2,

    // in-order retirement from the head
    output rename_pkg::rob_tag_t       retire_tag,
    output rename_pkg::retire_packet_t retire
);
    import rename_pkg::*;

    reg_addr_t entry_dest  [`ROB_SIZE];
    xlen_t     entry_value [`ROB_SIZE];
    logic [`ROB_SIZE-1:0] entry_ready;

    rob_tag_t head;
    rob_tag_t tail;
    logic [`ROB_CNT_LEN-1:0] count;

    logic do_retire;

    // head is ready and there is something in flight
    assign do_retire = (count != '0) && entry_ready[head];

    assign alloc_tag = tail;
    // size is a power of two, so the top count bit means full
    assign rob_full  = count[`ROB_CNT_LEN-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            entry_ready <= '0;
        end else begin
            if (alloc) begin
                tail              <= tail + 1'b1;
                entry_ready[tail] <= 1'b0;
            end
            if (do_retire) begin
                head <= head + 1'b1;
            end
            case ({alloc, do_retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // cdb only targets allocated slots, never the tail
            if (cdb.valid) begin
                entry_ready[cdb.tag] <= 1'b1;
            end
        end
    end

    // no destination is recorded as r0, which the register file ignores
    always_ff @(posedge clk) begin
        if (alloc) begin
            entry_dest[tail] <= alloc_has_dest ? alloc_dest : '0;
        end
        if (cdb.valid) begin
            entry_value[cdb.tag] <= cdb.data;
        end
    end

    assign ready1 = entry_ready[query_tag1];
    assign ready2 = entry_ready[query_tag2];
    assign value1 = entry_value[query_tag1];
    assign value2 = entry_value[query_tag2];

    assign retire_tag      = head;
    assign retire.valid    = do_retire;
    assign retire.reg_addr = entry_dest[head];
    assign retire.data     = entry_value[head];

endmodule

// ==== hdl/map_table.sv ====
`timescale 1ns/100ps

`include "dispatch_consts.svh"

module map_table (
    input  logic                       clk,
    input  logic                       reset,

    // source lookups for the held instruction
    input  rename_pkg::reg_addr_t      src1,
    input  rename_pkg::reg_addr_t      src2,
    output rename_pkg::map_entry_t     map_src1,
    output rename_pkg::map_entry_t     map_src2,

    // rename of the destination on dispatch
    input  logic                       alloc,
    input  rename_pkg::reg_addr_t      dest,
    input  logic                       has_dest,
    input  rename_pkg::rob_tag_t       alloc_tag,

    // retirement from the ROB head
    input  rename_pkg::rob_tag_t       retire_tag,
    input  rename_pkg::retire_packet_t retire
);
    import rename_pkg::*;

    map_entry_t map_q [`REG_NUM];

    logic retire_hit;
    logic rename_en;

    // only clear if no younger producer took the register over
    assign retire_hit = retire.valid && map_q[retire.reg_addr].busy &&
                        (map_q[retire.reg_addr].tag == retire_tag);

    // r0 is hardwired and never renamed
    assign rename_en = alloc && has_dest && (dest != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                map_q[i] <= '0;
            end
        end else begin
            if (retire_hit) begin
                map_q[retire.reg_addr] <= '0;
            end
            // rename comes last so it wins over a retire of the same register
            if (rename_en) begin
                map_q[dest] <= '{busy: 1'b1, tag: alloc_tag};
            end
        end
    end

    assign map_src1 = map_q[src1];
    assign map_src2 = map_q[src2];

endmodule

// ==== hdl/dispatch_ctrl.sv ====
`timescale 1ns/100ps

`include "dispatch_consts.svh"

module dispatch_ctrl (
    input  logic                    clk,
    input  logic                    reset,

    // from decode, only strobed while stall is low
    input  logic                    decoded_valid,
    input  inst_pkg::decoded_pack_t decoded,

    // station and ROB occupancy
    input  logic [`FU_NUM-1:0]      rs_full,
    input  logic                    rob_full,

    output inst_pkg::decoded_pack_t held,
    output logic                    fire,
    output logic [`FU_NUM-1:0]      rs_load,
    output logic                    stall
);
    import inst_pkg::*;

    dispatch_state_e state;

    // dispatch register, payload only
    always_ff @(posedge clk) begin
        if (decoded_valid) begin
            held <= decoded;
        end
    end

    // a new strobe in the firing cycle keeps the register occupied
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DISP_EMPTY;
        end else if (decoded_valid) begin
            state <= DISP_HELD;
        end else if (fire) begin
            state <= DISP_EMPTY;
        end
    end

    // needs room in the target station and a free ROB slot
    assign fire = (state == DISP_HELD) && !rs_full[held.fu] && !rob_full;

    // holding something that cannot leave this cycle
    assign stall = (state == DISP_HELD) && !fire;

    // one-hot load toward the selected station
    always_comb begin
        rs_load = '0;
        if (fire) begin
            rs_load[held.fu] = 1'b1;
        end
    end

endmodule

// ==== hdl/inst_pkg.sv ====
package inst_pkg;

    // also the bit index into rs_full and rs_load
    typedef enum logic [1:0] {
        FU_ALU  = 2'd0,
        FU_MULT = 2'd1,
        FU_BTU  = 2'd2,
        FU_LSU  = 2'd3
    } fu_e;

    typedef struct packed {
        fu_e                  fu;
        logic [3:0]           func;
        rename_pkg::reg_addr_t dest;
        logic                 has_dest;
        rename_pkg::reg_addr_t src1;
        rename_pkg::reg_addr_t src2;
        rename_pkg::xlen_t    imm;
        logic                 imm_valid;
        rename_pkg::xlen_t    pc;
        logic                 pc_valid;
    } decoded_pack_t;

    typedef struct packed {
        fu_e                  fu;
        logic [3:0]           func;
        rename_pkg::rob_tag_t tag_dest;
        rename_pkg::rob_tag_t tag_src1;
        rename_pkg::rob_tag_t tag_src2;
        logic                 ready_src1;
        logic                 ready_src2;
        rename_pkg::xlen_t    value_src1;
        rename_pkg::xlen_t    value_src2;
        rename_pkg::xlen_t    imm;
        rename_pkg::xlen_t    pc;
    } rs_entry_t;

    typedef enum logic {
        DISP_EMPTY,
        DISP_HELD
    } dispatch_state_e;

endpackage

// ==== hdl/rename_pkg.sv ====
`include "dispatch_consts.svh"

package rename_pkg;

    typedef logic [`REG_ADDR_LEN-1:0] reg_addr_t;
    typedef logic [`ROB_TAG_LEN-1:0] rob_tag_t;
    typedef logic [`XLEN-1:0] xlen_t;

    // where a source operand currently lives
    typedef enum logic [1:0] {
        SRC_REGFILE,
        SRC_ROB_READY,
        SRC_PENDING
    } src_stat_e;

    typedef struct packed {
        logic     busy;
        rob_tag_t tag;
    } map_entry_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        xlen_t    data;
    } cdb_packet_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t reg_addr;
        xlen_t     data;
    } retire_packet_t;

endpackage

// ==== hdl/dispatch_consts.svh ====
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// datapath and architectural register file
`define XLEN 32
`define REG_NUM 32
`define REG_ADDR_LEN 5

// reorder buffer, power of two
`define ROB_SIZE 8
`define ROB_TAG_LEN 3
// one more bit than the tag so a full buffer can be told from an empty one
`define ROB_CNT_LEN 4

// ALU, MULT, BTU, LSU
`define FU_NUM 4

`endif
